//--- rr_record_top.f
+incdir+include
verilog/rr_pkg.sv
verilog/rr_channel_logger.sv
verilog/rr_log_merger.sv
verilog/rr_csrs.sv
verilog/rr_record_top.sv
tests/tb_rr_record_top.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_rr_record_top
FILELIST = rr_record_top.f
OBJ_DIR  = obj_dir
PASS_MSG = Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- include/rr_tb_checks.svh
`ifndef RR_TB_CHECKS_SVH
`define RR_TB_CHECKS_SVH

// mismatch counts per compare kind
int n_err_log = 0;
int n_err_chan = 0;
int n_err_reg = 0;
// compares performed
int n_checks = 0;

// merged log word
task automatic check_log(input string name, input log_entry_t got, input log_entry_t exp);
  n_checks++;
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got seq=%0d ch=%0d data=%h, exp seq=%0d ch=%0d data=%h",
             $time, name, got.seq, got.chan_id, got.data, exp.seq, exp.chan_id, exp.data);
    n_err_log++;
  end
endtask

// forward channel signals
task automatic check_chan(input string name, input chan_t got, input chan_t exp);
  n_checks++;
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got valid=%b data=%h, exp valid=%b data=%h",
             $time, name, got.valid, got.data, exp.valid, exp.data);
    n_err_chan++;
  end
endtask

// register read data
task automatic check_reg(input string name, input logic [31:0] got, input logic [31:0] exp);
  n_checks++;
  if (got !== exp) begin
    $display("[ERROR] %0t %s: got %h, exp %h", $time, name, got, exp);
    n_err_reg++;
  end
endtask

`endif

//--- tests/tb_rr_record_top.sv
`timescale 1ns/1ps

module tb_rr_record_top import rr_pkg::*; ();

  // traffic phase lengths in cycles
  localparam int N_OFF = 150;
  localparam int N_FAST = 300;
  localparam int N_SLOW = 250;
  localparam int ACK_MAX_FAST = 2;
  localparam int ACK_MAX_SLOW = 16;
  // reset, drain and register accesses fit in the extra 100
  localparam int TOTAL_CYC = N_OFF + N_FAST + N_SLOW + 100;
  localparam int MAX_ENTRIES = (N_FAST + N_SLOW) * NUM_CHAN;
  localparam longint WD_CYCLES = TOTAL_CYC * 4 + ACK_MAX_SLOW * MAX_ENTRIES;
  // full loggers plus the word in flight, each at the slowest ack
  localparam int DRAIN_MAX = (NUM_CHAN * LOG_FIFO_DEPTH + 2) * (2 * ACK_MAX_SLOW + 8);

  logic                  clk = 1'b0;
  logic                  rstn;
  chan_t [NUM_CHAN-1:0]  sh_chan;
  logic [NUM_CHAN-1:0]   sh_ready;
  chan_t [NUM_CHAN-1:0]  cl_chan;
  logic [NUM_CHAN-1:0]   cl_ready;
  cfg_req_t              cfg;
  logic [CSR_DATA_W-1:0] cfg_rdata;
  log_entry_t            log_word;
  logic                  log_req;
  logic                  log_ack;

  int                    seed = 84;
  int                    ack_max = ACK_MAX_FAST;
  int                    exp_seq = 0;
  // acks raised by the storage model
  int                    exp_count = 0;
  int                    n_err_misc = 0;
  int                    n_stall = 0;
  // model of the record enable that follows the mode writes
  bit                    rec_model = 1'b0;
  bit                    rec_ever = 1'b0;
  // beat offered but not taken stays on the bus
  logic [NUM_CHAN-1:0]   held = '0;
  logic                  prev_req = 1'b0;
  log_entry_t            prev_log;
  // per-channel transfers seen while recording and consumed through rd_idx
  logic [DATA_W-1:0]     exp_q [NUM_CHAN][$];
  int                    rd_idx [NUM_CHAN] = '{default: 0};

  `include "rr_tb_checks.svh"

  always #5 clk = ~clk;

  rr_record_top i_rr_record_top (
    .clk         (clk),
    .rstn        (rstn),
    .i_sh_chan   (sh_chan),
    .o_sh_ready  (sh_ready),
    .o_cl_chan   (cl_chan),
    .i_cl_ready  (cl_ready),
    .i_cfg       (cfg),
    .o_cfg_rdata (cfg_rdata),
    .o_log       (log_word),
    .o_log_req   (log_req),
    .i_log_ack   (log_ack)
  );

  function automatic int pending_entries();
    int n;
    n = 0;
    for (int c = 0; c < NUM_CHAN; c++) begin
      n += exp_q[c].size() - rd_idx[c];
    end
    return n;
  endfunction

  ////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////
  task automatic cfg_write(input logic [CSR_ADDR_W-1:0] addr, input logic [31:0] data);
    @(posedge clk);
    cfg <= '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
    @(posedge clk);
    cfg <= '0;
  endtask

  // rdata is registered and valid at the negedge after the strobe edge
  task automatic cfg_read_check(input string name, input logic [CSR_ADDR_W-1:0] addr,
                                input logic [31:0] exp);
    @(posedge clk);
    cfg <= '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
    @(posedge clk);
    cfg <= '0;
    @(negedge clk);
    check_reg(name, cfg_rdata, exp);
  endtask

  task automatic drive_traffic(input int cycles);
    logic [31:0] r;
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      for (int c = 0; c < NUM_CHAN; c++) begin
        r = $random(seed);
        if (!held[c]) begin
          sh_chan[c] <= '{valid: r[0], data: $random(seed)};
        end
        // user side ready about 3 cycles in 4
        cl_ready[c] <= (r[2:1] != 2'b00);
      end
    end
  endtask

  // let offered beats complete and then leave the channels idle
  task automatic stop_traffic();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (held[c]) begin
          busy = 1'b1;
        end else begin
          sh_chan[c] <= '0;
        end
        cl_ready[c] <= 1'b1;
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // reference model sampled at the negedge
  ////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (!rec_model) begin
          check_chan($sformatf("o_cl_chan[%0d]", c), cl_chan[c], sh_chan[c]);
        end else if ((cl_chan[c].valid & cl_ready[c]) != (sh_chan[c].valid & sh_ready[c])) begin
          $display("channel %0d completed a beat on one side only at %0t", c, $time);
          n_err_misc++;
        end
        // beat completes on the coming edge
        if (rec_model && sh_chan[c].valid && sh_ready[c]) begin
          exp_q[c].push_back(sh_chan[c].data);
        end
        if (rec_model && sh_chan[c].valid && cl_ready[c] && !sh_ready[c]) begin
          n_stall++;
        end
        held[c] = sh_chan[c].valid & ~sh_ready[c];
      end
      if (!rec_model) begin
        check_reg("o_sh_ready", 32'(sh_ready), 32'(cl_ready));
      end
      if (log_req && !rec_ever) begin
        $display("log request raised before recording was enabled at %0t", $time);
        n_err_misc++;
      end
      // log word frozen while req is high
      if (log_req && prev_req) begin
        check_log("o_log hold", log_word, prev_log);
      end
      prev_req = log_req;
      prev_log = log_word;
      // new mode applies after the coming edge
      if (cfg.wr && cfg.addr == CSR_MODE) begin
        rec_model = cfg.wdata[MODE_REC_EN_BIT];
        rec_ever = rec_ever | rec_model;
      end
    end
  end

  // storage side model with four-phase handshake and random ack delays
  initial begin : storage_side
    logic [31:0] r;
    log_entry_t  exp_word;
    int          ch;
    log_ack <= 1'b0;
    forever begin
      @(negedge clk);
      if (log_req) begin
        ch = int'(log_word.chan_id);
        if (rd_idx[ch] >= exp_q[ch].size()) begin
          $display("log entry for channel %0d at %0t has no matching transfer", ch, $time);
          n_err_misc++;
        end else begin
          exp_word = '{seq: SEQ_W'(exp_seq), chan_id: log_word.chan_id,
                       data: exp_q[ch][rd_idx[ch]]};
          check_log("o_log", log_word, exp_word);
          rd_idx[ch]++;
        end
        exp_seq++;
        r = $random(seed);
        repeat (int'(r[7:0]) % (ack_max + 1)) @(posedge clk);
        @(posedge clk);
        log_ack <= 1'b1;
        exp_count++;
        @(negedge clk);
        while (log_req) @(negedge clk);
        r = $random(seed);
        repeat (int'(r[7:0]) % (ack_max + 1)) @(posedge clk);
        @(posedge clk);
        log_ack <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////
  // test sequence and report
  ////////////////////////////////////////////////////
  initial begin : stimulus
    int n_err;
    int drain_cyc;
    rstn <= 1'b0;
    sh_chan <= '0;
    cl_ready <= '0;
    cfg <= '0;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    // pure pass-through with recording off
    drive_traffic(N_OFF);
    cfg_write(CSR_MODE, 32'h1);
    drive_traffic(N_FAST);
    // slow storage side fills the loggers until they stall
    ack_max = ACK_MAX_SLOW;
    n_stall = 0;
    drive_traffic(N_SLOW);
    stop_traffic();
    drain_cyc = 0;
    while ((pending_entries() != 0 || log_req || log_ack) && drain_cyc < DRAIN_MAX) begin
      @(negedge clk);
      drain_cyc++;
    end
    if (pending_entries() != 0) begin
      $display("%0d recorded transfers never appeared in the log", pending_entries());
      n_err_misc++;
    end
    if (log_req || log_ack) begin
      $display("log handshake still busy at the end of the drain time");
      n_err_misc++;
    end
    repeat (10) @(negedge clk);
    cfg_read_check("o_cfg_rdata mode", CSR_MODE, 32'h1);
    cfg_read_check("o_cfg_rdata count", CSR_COUNT, 32'(exp_count));
    cfg_read_check("o_cfg_rdata unused", 4'd5, 32'h0);
    cfg_write(CSR_MODE, 32'h0);
    cfg_read_check("o_cfg_rdata mode", CSR_MODE, 32'h0);
    if (n_stall == 0) begin
      $display("no channel stall was seen while the storage side was slow");
      n_err_misc++;
    end
    n_err = n_err_log + n_err_chan + n_err_reg + n_err_misc;
    $display("errors: log %0d, chan %0d, reg %0d, other %0d in %0d checks, %0d entries",
             n_err_log, n_err_chan, n_err_reg, n_err_misc, n_checks, exp_count);
    if (n_err == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin : watchdog
    #(WD_CYCLES * 10);
    $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- verilog/rr_record_top.sv
`timescale 1ns/1ps

module rr_record_top import rr_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  chan_t [NUM_CHAN-1:0]  i_sh_chan,
  output logic [NUM_CHAN-1:0]   o_sh_ready,
  output chan_t [NUM_CHAN-1:0]  o_cl_chan,
  input  logic [NUM_CHAN-1:0]   i_cl_ready,
  input  cfg_req_t              i_cfg,
  output logic [CSR_DATA_W-1:0] o_cfg_rdata,
  output log_entry_t            o_log,
  output logic                  o_log_req,
  input  logic                  i_log_ack
);

  logic                            record_en;
  logic                            logged;
  logic [NUM_CHAN-1:0]             entry_valid;
  logic [NUM_CHAN-1:0][DATA_W-1:0] entry_data;
  logic [NUM_CHAN-1:0]             entry_pop;

  //////////////////////////////////////////////////
  // configuration
  //////////////////////////////////////////////////
  rr_csrs u_csrs (
    .clk         (clk),
    .rstn        (rstn),
    .i_cfg       (i_cfg),
    .o_cfg_rdata (o_cfg_rdata),
    .i_logged    (logged),
    .o_record_en (record_en)
  );

  //////////////////////////////////////////////////
  // one logger per channel
  //////////////////////////////////////////////////
  for (genvar c = 0; c < NUM_CHAN; c++) begin : g_logger
    rr_channel_logger u_logger (
      .clk           (clk),
      .rstn          (rstn),
      .i_record_en   (record_en),
      .i_sh_chan     (i_sh_chan[c]),
      .o_sh_ready    (o_sh_ready[c]),
      .o_cl_chan     (o_cl_chan[c]),
      .i_cl_ready    (i_cl_ready[c]),
      .o_entry_valid (entry_valid[c]),
      .o_entry_data  (entry_data[c]),
      .i_entry_pop   (entry_pop[c])
    );
  end

  //////////////////////////////////////////////////
  // merge into the storage stream
  //////////////////////////////////////////////////
  rr_log_merger u_merger (
    .clk           (clk),
    .rstn          (rstn),
    .i_entry_valid (entry_valid),
    .i_entry_data  (entry_data),
    .o_entry_pop   (entry_pop),
    .o_log         (o_log),
    .o_log_req     (o_log_req),
    .i_log_ack     (i_log_ack),
    .o_logged      (logged)
  );

endmodule

//--- verilog/rr_csrs.sv
`timescale 1ns/1ps

module rr_csrs import rr_pkg::*; (
  input  logic                  clk,
  input  logic                  rstn,
  input  cfg_req_t              i_cfg,
  output logic [CSR_DATA_W-1:0] o_cfg_rdata,
  input  logic                  i_logged,
  output logic                  o_record_en
);

  // completed log exchanges
  logic [CSR_DATA_W-1:0] logged_cnt;
  logic                  mode_wr;
  logic [CSR_DATA_W-1:0] mode_rd;

  //////////////////////////////////////////////////
  // mode register
  //////////////////////////////////////////////////
  assign mode_wr = i_cfg.wr & (i_cfg.addr == CSR_MODE);

  // new enable is seen by the loggers one cycle after the write
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_record_en <= 1'b0;
    end else if (mode_wr) begin
      o_record_en <= i_cfg.wdata[MODE_REC_EN_BIT];
    end
  end

  // other mode bits read back as zero
  assign mode_rd = CSR_DATA_W'(o_record_en) << MODE_REC_EN_BIT;

  //////////////////////////////////////////////////
  // entry counter
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rstn) begin
      logged_cnt <= '0;
    end else if (i_logged) begin
      logged_cnt <= logged_cnt + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////
  // data valid the cycle after the strobe, held until the next read
  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_cfg_rdata <= '0;
    end else if (i_cfg.rd) begin
      case (i_cfg.addr)
        CSR_MODE: begin
          o_cfg_rdata <= mode_rd;
        end
        CSR_COUNT: begin
          o_cfg_rdata <= logged_cnt;
        end
        default: begin
          // unmapped
          o_cfg_rdata <= '0;
        end
      endcase
    end
  end

endmodule

//--- verilog/rr_log_merger.sv
`timescale 1ns/1ps

module rr_log_merger import rr_pkg::*; (
  input  logic                            clk,
  input  logic                            rstn,
  input  logic [NUM_CHAN-1:0]             i_entry_valid,
  input  logic [NUM_CHAN-1:0][DATA_W-1:0] i_entry_data,
  output logic [NUM_CHAN-1:0]             o_entry_pop,
  output log_entry_t                      o_log,
  output logic                            o_log_req,
  input  logic                            i_log_ack,
  output logic                            o_logged
);

  logic [MRG_STATE_W-1:0] state;
  logic [SEQ_W-1:0]       next_seq;
  // channel served most recently
  logic [CHAN_ID_W-1:0]   last_chan;
  logic [CHAN_ID_W-1:0]   cand;
  logic [CHAN_ID_W-1:0]   pick_idx;
  logic                   pick_found;
  logic                   take;

  //////////////////////////////////////////////////
  // round-robin pick
  //////////////////////////////////////////////////
  // scan starts right after last_chan, last_chan itself comes last
  // index arithmetic wraps at NUM_CHAN
  always_comb begin
    pick_found = 1'b0;
    pick_idx = last_chan;
    cand = last_chan;
    for (int i = 1; i <= NUM_CHAN; i++) begin
      cand = last_chan + CHAN_ID_W'(i);
      if (!pick_found && i_entry_valid[cand]) begin
        pick_found = 1'b1;
        pick_idx = cand;
      end
    end
  end

  // new entry only between exchanges
  assign take = (state == MRG_IDLE) & pick_found;

  // one-cycle pop to the chosen logger, same edge as the capture
  always_comb begin
    o_entry_pop = '0;
    o_entry_pop[pick_idx] = take;
  end

  //////////////////////////////////////////////////
  // four-phase handshake
  //////////////////////////////////////////////////
  // idle -> req (req high) -> ack_low (req low) -> idle
  assign o_log_req = (state == MRG_REQ);
  // ack seen high closes the exchange for the counter
  assign o_logged = o_log_req & i_log_ack;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= MRG_IDLE;
      next_seq <= '0;
      // first scan begins at channel 0
      last_chan <= CHAN_ID_W'(NUM_CHAN - 1);
    end else begin
      case (state)
        MRG_IDLE: begin
          if (take) begin
            state <= MRG_REQ;
            next_seq <= next_seq + 1'b1;
            last_chan <= pick_idx;
          end
        end
        MRG_REQ: begin
          if (i_log_ack) begin
            state <= MRG_ACK_LOW;
          end
        end
        MRG_ACK_LOW: begin
          // storage side must release ack before the next word
          if (!i_log_ack) begin
            state <= MRG_IDLE;
          end
        end
        default: begin
          state <= MRG_IDLE;
        end
      endcase
    end
  end

  // log word is loaded together with req rising and held until idle
  always_ff @(posedge clk) begin
    if (take) begin
      o_log.seq <= next_seq;
      o_log.chan_id <= pick_idx;
      o_log.data <= i_entry_data[pick_idx];
    end
  end

endmodule

//--- verilog/rr_channel_logger.sv
`timescale 1ns/1ps

module rr_channel_logger import rr_pkg::*; (
  input  logic              clk,
  input  logic              rstn,
  input  logic              i_record_en,
  input  chan_t             i_sh_chan,
  output logic              o_sh_ready,
  output chan_t             o_cl_chan,
  input  logic              i_cl_ready,
  output logic              o_entry_valid,
  output logic [DATA_W-1:0] o_entry_data,
  input  logic              i_entry_pop
);

  // log storage, payload only
  logic [DATA_W-1:0]    fifo_mem [LOG_FIFO_DEPTH];
  logic [LOG_PTR_W-1:0] wr_ptr;
  logic [LOG_PTR_W-1:0] rd_ptr;
  logic [LOG_CNT_W-1:0] fill;
  logic                 fifo_full;
  logic                 stall;
  logic                 push;
  logic                 pop;

  //////////////////////////////////////////////////
  // forward path
  //////////////////////////////////////////////////
  assign fifo_full = (fill == LOG_CNT_W'(LOG_FIFO_DEPTH));
  // only a full log while recording blocks the channel
  assign stall = i_record_en & fifo_full;

  // both sides see the same gate, so a beat completes on both at once
  assign o_cl_chan.valid = i_sh_chan.valid & ~stall;
  assign o_cl_chan.data = i_sh_chan.data;
  assign o_sh_ready = i_cl_ready & ~stall;

  // completed beat while recording, never while full
  assign push = i_record_en & i_sh_chan.valid & o_sh_ready;

  //////////////////////////////////////////////////
  // log fifo
  //////////////////////////////////////////////////
  // head is visible to the merger the cycle after the push
  assign o_entry_valid = (fill != '0);
  assign o_entry_data = fifo_mem[rd_ptr];
  assign pop = i_entry_pop & o_entry_valid;

  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= i_sh_chan.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end else begin
      // pointers wrap at the depth
      if (push) begin
        wr_ptr <= (wr_ptr == LOG_PTR_W'(LOG_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == LOG_PTR_W'(LOG_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the level alone
      case ({push, pop})
        2'b10: begin
          fill <= fill + 1'b1;
        end
        2'b01: begin
          fill <= fill - 1'b1;
        end
        default: begin
          fill <= fill;
        end
      endcase
    end
  end

endmodule

//--- verilog/rr_pkg.sv
package rr_pkg;

  //////////////////////////////////////////////////
  // channel and log geometry
  //////////////////////////////////////////////////
  // logged channels, shell to user circuit
  localparam int NUM_CHAN = 4;
  // index width, NUM_CHAN is 2**CHAN_ID_W
  localparam int CHAN_ID_W = 2;
  localparam int DATA_W = 32;
  // entries buffered in each channel logger
  localparam int LOG_FIFO_DEPTH = 4;
  localparam int LOG_PTR_W = $clog2(LOG_FIFO_DEPTH);
  // fill level needs one more code than the pointers
  localparam int LOG_CNT_W = $clog2(LOG_FIFO_DEPTH + 1);
  // merged log sequence number
  localparam int SEQ_W = 16;

  //////////////////////////////////////////////////
  // register map
  //////////////////////////////////////////////////
  localparam int CSR_ADDR_W = 4;
  localparam int CSR_DATA_W = 32;
  localparam logic [CSR_ADDR_W-1:0] CSR_MODE = 4'd0;
  localparam logic [CSR_ADDR_W-1:0] CSR_COUNT = 4'd1;
  // record enable position inside the mode register
  localparam int MODE_REC_EN_BIT = 0;

  // merger handshake states
  localparam int MRG_STATE_W = 2;
  localparam logic [MRG_STATE_W-1:0] MRG_IDLE = 2'd0;
  localparam logic [MRG_STATE_W-1:0] MRG_REQ = 2'd1;
  localparam logic [MRG_STATE_W-1:0] MRG_ACK_LOW = 2'd2;

  //////////////////////////////////////////////////
  // bundled signals
  //////////////////////////////////////////////////
  // forward half of a valid/ready channel, 33 bits
  typedef struct packed {
    logic              valid;
    logic [DATA_W-1:0] data;
  } chan_t;

  // one merged log word, 50 bits
  typedef struct packed {
    logic [SEQ_W-1:0]     seq;
    logic [CHAN_ID_W-1:0] chan_id;
    logic [DATA_W-1:0]    data;
  } log_entry_t;

  // one register access, 38 bits
  typedef struct packed {
    logic                  wr;
    logic                  rd;
    logic [CSR_ADDR_W-1:0] addr;
    logic [CSR_DATA_W-1:0] wdata;
  } cfg_req_t;

endpackage
